// File: Bender.yml
package:
  name: processor

sources:
  - processorPkg.sv
  - fetchStage.sv
  - decodeStage.sv
  - aluUnit.sv
  - hazardUnit.sv
  - processor.sv
  - target: test
    files:
      - processor_assertions.sv
      - processorTb.sv

// File: aluUnit.sv
//--------------------------------------
// 32-bit ALU
// Add, subtract, and, or, signed slt,
// zero flag for branch compare
//--------------------------------------

`timescale 1ns/1ps

module aluUnit (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [2:0]  aluOp,
    output logic [31:0] result,
    output logic        zero
);

    always_comb begin
        case (aluOp)
            processorPkg::aluAdd: result = a + b;
            processorPkg::aluSub: result = a - b;
            processorPkg::aluAnd: result = a & b;
            processorPkg::aluOr:  result = a | b;
            processorPkg::aluSlt: result = {31'd0, $signed(a) < $signed(b)};
            default:              result = 32'd0;
        endcase
    end

    // Equal operands give zero on subtract
    assign zero = (result == 32'd0);

endmodule

// File: decodeStage.sv
//--------------------------------------
// Decode stage
// Control decode, register file with
// write-through and debug read port
//--------------------------------------

`timescale 1ns/1ps

module decodeStage (
    input  logic                  Clock,
    input  logic                  nReset,
    input  processorPkg::instrWord instr,
    input  logic                  wbWrite,
    input  logic [4:0]            wbAddr,
    input  logic [31:0]           wbData,
    input  logic [4:0]            RegAddr,
    output logic [31:0]           RegData,
    output logic [4:0]            rsAddr,
    output logic [4:0]            rtAddr,
    output logic [4:0]            destAddr,
    output logic [31:0]           rsData,
    output logic [31:0]           rtData,
    output logic [31:0]           immData,
    output logic [2:0]            aluOp,
    output logic                  aluSrcImm,
    output logic                  regWrite,
    output logic                  memRead,
    output logic                  memWrite,
    output logic                  branchEq,
    output logic                  branchNe
);

    logic [31:0] regs [32];

    // Register 0 reads zero, a same-cycle write shows through
    function automatic logic [31:0] readReg(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return 32'd0;
        end else if (wbWrite && wbAddr == addr) begin
            return wbData;
        end
        return regs[addr];
    endfunction

    // Control decode -------------------------
    always_comb begin
        rsAddr    = instr.rType.rs;
        rtAddr    = instr.rType.rt;
        destAddr  = instr.iType.rt;
        aluOp     = processorPkg::aluAdd;
        aluSrcImm = 1'b0;
        regWrite  = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        branchEq  = 1'b0;
        branchNe  = 1'b0;
        case (instr.rType.op)
            processorPkg::opRType: begin
                destAddr = instr.rType.rd;
                regWrite = 1'b1;
                case (instr.rType.funct)
                    processorPkg::fnAddu: aluOp = processorPkg::aluAdd;
                    processorPkg::fnSubu: aluOp = processorPkg::aluSub;
                    processorPkg::fnAnd:  aluOp = processorPkg::aluAnd;
                    processorPkg::fnOr:   aluOp = processorPkg::aluOr;
                    processorPkg::fnSlt:  aluOp = processorPkg::aluSlt;
                    default: begin
                        regWrite = 1'b0;
                        rsAddr   = 5'd0;
                        rtAddr   = 5'd0;
                    end
                endcase
            end
            processorPkg::opAddiu: begin
                // ADDIU does not read rt
                rtAddr    = 5'd0;
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
            end
            processorPkg::opLw: begin
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
                memRead   = 1'b1;
            end
            processorPkg::opSw: begin
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
            end
            processorPkg::opBeq: begin
                aluOp    = processorPkg::aluSub;
                branchEq = 1'b1;
            end
            processorPkg::opBne: begin
                aluOp    = processorPkg::aluSub;
                branchNe = 1'b1;
            end
            default: begin
                rsAddr = 5'd0;
                rtAddr = 5'd0;
            end
        endcase
    end

    assign immData = {{16{instr.iType.imm[15]}}, instr.iType.imm};

    // Register file --------------------------
    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wbWrite && wbAddr != 5'd0) begin
            regs[wbAddr] <= wbData;
        end
    end

    always_comb begin
        rsData  = readReg(rsAddr);
        rtData  = readReg(rtAddr);
        RegData = readReg(RegAddr);
    end

endmodule

// File: fetchStage.sv
//--------------------------------------
// Fetch stage
// Program counter with stall hold and
// branch redirect
//--------------------------------------

`timescale 1ns/1ps

module fetchStage (
    input  logic        Clock,
    input  logic        nReset,
    input  logic        nStall,
    input  logic        branchTaken,
    input  logic [15:0] branchTarget,
    output logic [15:0] InstrAddr
);

    // Taken branch wins over a stall
    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            InstrAddr <= processorPkg::resetAddr;
        end else if (branchTaken) begin
            InstrAddr <= branchTarget;
        end else if (nStall) begin
            InstrAddr <= InstrAddr + 16'd4;
        end
    end

endmodule

// File: hazardUnit.sv
//--------------------------------------
// Hazard unit
// Operand forwarding selects and
// load-use stall detection
//--------------------------------------

`timescale 1ns/1ps

module hazardUnit (
    input  logic [4:0] rsAddrE,
    input  logic [4:0] rtAddrE,
    input  logic [4:0] rsAddrD,
    input  logic [4:0] rtAddrD,
    input  logic [4:0] destAddrM,
    input  logic [4:0] destAddrW,
    input  logic       regWriteM,
    input  logic       regWriteW,
    input  logic       memReadE,
    output logic [1:0] fwdA,
    output logic [1:0] fwdB,
    output logic       nStall
);

    // Youngest producer first, never register 0
    function automatic logic [1:0] fwdFor(input logic [4:0] src);
        if (src == 5'd0) begin
            return processorPkg::fwdReg;
        end else if (regWriteM && destAddrM == src) begin
            return processorPkg::fwdMem;
        end else if (regWriteW && destAddrW == src) begin
            return processorPkg::fwdWb;
        end
        return processorPkg::fwdReg;
    endfunction

    always_comb begin
        fwdA = fwdFor(rsAddrE);
        fwdB = fwdFor(rtAddrE);
    end

    // Load data is not ready until writeback
    assign nStall = !(memReadE && rtAddrE != 5'd0 &&
                      (rtAddrE == rsAddrD || rtAddrE == rtAddrD));

endmodule

// File: processor.sv
//--------------------------------------
// Five-stage pipeline top level
// Pipeline registers, forwarding muxes,
// branch resolution, memory, writeback
//--------------------------------------

`timescale 1ns/1ps

module processor (
    input  logic        Clock,
    input  logic        nReset,
    input  logic [31:0] InstrMem,
    input  logic [31:0] MemData,
    input  logic [4:0]  RegAddr,
    output logic [31:0] WriteData,
    output logic [31:0] RegData,
    output logic [15:0] InstrAddr,
    output logic [15:0] MemAddr,
    output logic        MemWrite,
    output logic        MemRead,
    output logic        nStall
);

    processorPkg::instrWord instrD;
    logic [15:0] pcD, pcE, branchTarget;
    logic [4:0]  rsAddrD, rtAddrD, destAddrD, rsAddrE, rtAddrE, destAddrE;
    logic [31:0] rsDataD, rtDataD, immD, rsDataE, rtDataE, immE;
    logic [2:0]  aluOpD, aluOpE;
    logic        aluSrcImmD, regWriteD, memReadD, memWriteD, branchEqD, branchNeD;
    logic        aluSrcImmE, regWriteE, memReadE, memWriteE, branchEqE, branchNeE;
    logic [1:0]  fwdA, fwdB;
    logic [31:0] operandA, storeDataE, aluResultE;
    logic        zeroE, branchTaken;
    logic [4:0]  destAddrM, destAddrW;
    logic [31:0] aluResultM, storeDataM, aluResultW, wbData;
    logic        regWriteM, memReadM, memWriteM, regWriteW, memReadW;

    function automatic logic [31:0] pickOperand(
        input logic [1:0]  sel,
        input logic [31:0] regVal,
        input logic [31:0] memVal,
        input logic [31:0] wbVal
    );
        case (sel)
            processorPkg::fwdMem: return memVal;
            processorPkg::fwdWb:  return wbVal;
            default:              return regVal;
        endcase
    endfunction

    fetchStage u_fetch (
        .Clock(Clock), .nReset(nReset), .nStall(nStall),
        .branchTaken(branchTaken), .branchTarget(branchTarget), .InstrAddr(InstrAddr)
    );

    // Fetch/decode, flushed to the all-zero no-op
    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            instrD <= '0;
            pcD    <= processorPkg::resetAddr;
        end else if (branchTaken) begin
            instrD <= '0;
        end else if (nStall) begin
            instrD <= InstrMem;
            pcD    <= InstrAddr;
        end
    end

    decodeStage u_decode (
        .Clock(Clock), .nReset(nReset), .instr(instrD),
        .wbWrite(regWriteW), .wbAddr(destAddrW), .wbData(wbData),
        .RegAddr(RegAddr), .RegData(RegData),
        .rsAddr(rsAddrD), .rtAddr(rtAddrD), .destAddr(destAddrD),
        .rsData(rsDataD), .rtData(rtDataD), .immData(immD), .aluOp(aluOpD),
        .aluSrcImm(aluSrcImmD), .regWrite(regWriteD), .memRead(memReadD),
        .memWrite(memWriteD), .branchEq(branchEqD), .branchNe(branchNeD)
    );

    hazardUnit u_hazard (
        .rsAddrE(rsAddrE), .rtAddrE(rtAddrE), .rsAddrD(rsAddrD), .rtAddrD(rtAddrD),
        .destAddrM(destAddrM), .destAddrW(destAddrW), .regWriteM(regWriteM),
        .regWriteW(regWriteW), .memReadE(memReadE),
        .fwdA(fwdA), .fwdB(fwdB), .nStall(nStall)
    );

    // Decode/execute, bubble on stall or flush
    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            regWriteE <= 1'b0;
            memReadE  <= 1'b0;
            memWriteE <= 1'b0;
            branchEqE <= 1'b0;
            branchNeE <= 1'b0;
        end else if (branchTaken || !nStall) begin
            regWriteE <= 1'b0;
            memReadE  <= 1'b0;
            memWriteE <= 1'b0;
            branchEqE <= 1'b0;
            branchNeE <= 1'b0;
        end else begin
            regWriteE <= regWriteD;
            memReadE  <= memReadD;
            memWriteE <= memWriteD;
            branchEqE <= branchEqD;
            branchNeE <= branchNeD;
        end
    end

    always_ff @(posedge Clock) begin
        rsAddrE    <= rsAddrD;
        rtAddrE    <= rtAddrD;
        destAddrE  <= destAddrD;
        rsDataE    <= rsDataD;
        rtDataE    <= rtDataD;
        immE       <= immD;
        aluOpE     <= aluOpD;
        aluSrcImmE <= aluSrcImmD;
        pcE        <= pcD;
    end

    // Execute --------------------------------
    assign operandA   = pickOperand(fwdA, rsDataE, aluResultM, wbData);
    assign storeDataE = pickOperand(fwdB, rtDataE, aluResultM, wbData);

    aluUnit u_alu (
        .a(operandA), .b(aluSrcImmE ? immE : storeDataE), .aluOp(aluOpE),
        .result(aluResultE), .zero(zeroE)
    );

    assign branchTarget = pcE + 16'd4 + {immE[13:0], 2'b00};
    assign branchTaken  = (branchEqE && zeroE) || (branchNeE && !zeroE);

    // Execute/memory and memory/writeback
    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            regWriteM <= 1'b0;
            memReadM  <= 1'b0;
            memWriteM <= 1'b0;
            regWriteW <= 1'b0;
            memReadW  <= 1'b0;
        end else begin
            regWriteM <= regWriteE;
            memReadM  <= memReadE;
            memWriteM <= memWriteE;
            regWriteW <= regWriteM;
            memReadW  <= memReadM;
        end
    end

    always_ff @(posedge Clock) begin
        destAddrM  <= destAddrE;
        aluResultM <= aluResultE;
        storeDataM <= storeDataE;
        destAddrW  <= destAddrM;
        aluResultW <= aluResultM;
    end

    assign MemAddr   = aluResultM[15:0];
    assign WriteData = storeDataM;
    assign MemWrite  = memWriteM;
    assign MemRead   = memReadM;

    // Load data arrives one cycle after MemRead
    assign wbData = memReadW ? MemData : aluResultW;

endmodule

// File: processorPkg.sv
//--------------------------------------
// Shared definitions of the pipeline
// Opcodes, function codes, ALU codes,
// forwarding selects, instruction word
//--------------------------------------

package processorPkg;

    // Primary opcodes
    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opBne   = 6'h05;

    // R-type function codes
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnSlt  = 6'h2a;

    // ALU operations chosen in decode
    localparam logic [2:0] aluAdd = 3'd0;
    localparam logic [2:0] aluSub = 3'd1;
    localparam logic [2:0] aluAnd = 3'd2;
    localparam logic [2:0] aluOr  = 3'd3;
    localparam logic [2:0] aluSlt = 3'd4;

    // Operand sources in execute
    localparam logic [1:0] fwdReg = 2'd0;
    localparam logic [1:0] fwdMem = 2'd1;
    localparam logic [1:0] fwdWb  = 2'd2;

    localparam logic [15:0] resetAddr = 16'h0000;

    // One instruction word, two views
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rType;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } iType;
    } instrWord;

endpackage

// File: processorTb.sv
//--------------------------------------
// Testbench of the five-stage pipeline
// Program table, instruction-level model,
// memory models, LFSR, checks, timeout
//--------------------------------------

`timescale 1ns/1ps

module processorTb;

    localparam int progLen = 26;
    localparam int cycleLimit = progLen * 3 + 20;

    logic        Clock = 1'b0;
    logic        nReset = 1'b0;
    logic [31:0] InstrMem;
    logic [31:0] MemData = 32'd0;
    logic [4:0]  RegAddr = 5'd0;
    logic [31:0] WriteData, RegData;
    logic [15:0] InstrAddr, MemAddr;
    logic        MemWrite, MemRead, nStall;

    processorPkg::instrWord prog [progLen];
    logic [31:0] dmem [64];
    logic [31:0] modelMem [64];
    logic [31:0] modelRegs [32];
    logic [15:0] storeAddrQ [$];
    logic [31:0] storeDataQ [$];
    logic [31:0] lfsrState = 32'h3eb7d8a8;
    logic [15:0] finalAddr;
    int          loadUsePairs;
    int          stallCycles = 0;
    int          cycles = 0;
    int          redirectCycles = 0;
    logic        done = 1'b0;

    processor u_dut (.*);

    bind processor processor_assertions u_assert (
        .Clock(Clock), .nReset(nReset), .MemWrite(MemWrite), .MemRead(MemRead),
        .nStall(nStall), .branchTaken(branchTaken), .branchTarget(branchTarget),
        .InstrAddr(InstrAddr)
    );

    always #2 Clock = ~Clock;

    // Instruction memory answers combinationally, no-ops past the program
    assign InstrMem = (InstrAddr[15:2] < progLen) ? prog[InstrAddr[15:2]] : 32'd0;

    // Data memory, read data one cycle after MemRead
    always @(posedge Clock) begin
        if (MemWrite) begin
            dmem[MemAddr[7:2]] <= WriteData;
        end
        if (MemRead) begin
            MemData <= dmem[MemAddr[7:2]];
        end
    end

    // Helpers --------------------------------
    function automatic logic [31:0] nextRandomWord();
        logic [31:0] word;
        logic        fb;
        word = '0;
        for (int i = 0; i < 32; i++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            word = {word[30:0], fb};
        end
        return word;
    endfunction

    function automatic processorPkg::instrWord rInstr(
        input logic [5:0] fn, input logic [4:0] rd, input logic [4:0] rs, input logic [4:0] rt
    );
        processorPkg::instrWord w;
        w.rType.op    = processorPkg::opRType;
        w.rType.rs    = rs;
        w.rType.rt    = rt;
        w.rType.rd    = rd;
        w.rType.shamt = 5'd0;
        w.rType.funct = fn;
        return w;
    endfunction

    function automatic processorPkg::instrWord iInstr(
        input logic [5:0] op, input logic [4:0] rt, input logic [4:0] rs, input logic [15:0] imm
    );
        processorPkg::instrWord w;
        w.iType.op  = op;
        w.iType.rs  = rs;
        w.iType.rt  = rt;
        w.iType.imm = imm;
        return w;
    endfunction

    task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic checkAddr(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    // Instruction-level model ----------------
    task automatic runModel();
        processorPkg::instrWord w;
        logic [31:0] a, b, simm, addr;
        logic [4:0]  lastLoad;
        logic        lastWasLoad, readsRt, halted;
        int          pc, nextPc, steps;
        pc = 0;
        steps = 0;
        lastWasLoad = 1'b0;
        lastLoad = 5'd0;
        halted = 1'b0;
        loadUsePairs = 0;
        while (!halted && steps < 1000) begin
            w = prog[pc];
            a = modelRegs[w.rType.rs];
            b = modelRegs[w.rType.rt];
            simm = {{16{w.iType.imm[15]}}, w.iType.imm};
            addr = a + simm;
            readsRt = (w.rType.op == processorPkg::opRType) || (w.rType.op == processorPkg::opSw)
                || (w.rType.op == processorPkg::opBeq) || (w.rType.op == processorPkg::opBne);
            if (lastWasLoad && lastLoad != 5'd0 &&
                (lastLoad == w.rType.rs || (readsRt && lastLoad == w.rType.rt))) begin
                loadUsePairs++;
            end
            lastWasLoad = 1'b0;
            nextPc = pc + 1;
            steps++;
            case (w.rType.op)
                processorPkg::opRType: begin
                    case (w.rType.funct)
                        processorPkg::fnAddu: modelRegs[w.rType.rd] = a + b;
                        processorPkg::fnSubu: modelRegs[w.rType.rd] = a - b;
                        processorPkg::fnAnd:  modelRegs[w.rType.rd] = a & b;
                        processorPkg::fnOr:   modelRegs[w.rType.rd] = a | b;
                        processorPkg::fnSlt:
                            modelRegs[w.rType.rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: ;
                    endcase
                end
                processorPkg::opAddiu: modelRegs[w.iType.rt] = a + simm;
                processorPkg::opLw: begin
                    modelRegs[w.iType.rt] = modelMem[addr[7:2]];
                    lastWasLoad = 1'b1;
                    lastLoad = w.iType.rt;
                end
                processorPkg::opSw: begin
                    modelMem[addr[7:2]] = b;
                    storeAddrQ.push_back(addr[15:0]);
                    storeDataQ.push_back(b);
                end
                processorPkg::opBeq, processorPkg::opBne: begin
                    if ((a == b) == (w.rType.op == processorPkg::opBeq)) begin
                        nextPc = pc + 1 + $signed(simm);
                    end
                end
                default: ;
            endcase
            modelRegs[0] = 32'd0;
            // A branch to itself ends the program
            if (nextPc == pc) begin
                halted = 1'b1;
            end
            pc = nextPc;
        end
        finalAddr = 16'(pc * 4);
    endtask

    // Store, stall and timeout monitors
    always @(posedge Clock) begin
        if (nReset && MemWrite) begin
            if (storeAddrQ.size() == 0) begin
                $display("store issued that the program does not contain");
                $display("** FAIL **");
                $fatal(1);
            end else begin
                checkAddr("MemAddr", MemAddr, storeAddrQ.pop_front());
                checkWord("WriteData", WriteData, storeDataQ.pop_front());
            end
        end
        if (nReset && !done) begin
            cycles <= cycles + 1;
            if (!nStall) begin
                stallCycles <= stallCycles + 1;
            end
            if (cycles >= cycleLimit) begin
                $display("timeout: program did not reach its final address");
                $display("** FAIL **");
                $fatal(1);
            end
        end
    end

    initial begin
        // Table rows: dependent chains, load-use pairs, branches
        prog[0]  = iInstr(processorPkg::opAddiu, 5'd1, 5'd0, 16'd16);
        prog[1]  = iInstr(processorPkg::opAddiu, 5'd2, 5'd1, 16'd5);
        prog[2]  = rInstr(processorPkg::fnAddu, 5'd3, 5'd1, 5'd2);
        prog[3]  = rInstr(processorPkg::fnSubu, 5'd4, 5'd3, 5'd1);
        prog[4]  = rInstr(processorPkg::fnAnd, 5'd5, 5'd3, 5'd2);
        prog[5]  = rInstr(processorPkg::fnOr, 5'd6, 5'd4, 5'd5);
        prog[6]  = rInstr(processorPkg::fnSlt, 5'd7, 5'd4, 5'd3);
        prog[7]  = iInstr(processorPkg::opAddiu, 5'd0, 5'd0, 16'd7);
        prog[8]  = rInstr(processorPkg::fnAddu, 5'd8, 5'd0, 5'd7);
        prog[9]  = iInstr(processorPkg::opLw, 5'd9, 5'd1, 16'd0);
        prog[10] = rInstr(processorPkg::fnAddu, 5'd10, 5'd9, 5'd2);
        prog[11] = iInstr(processorPkg::opSw, 5'd10, 5'd1, 16'd4);
        prog[12] = iInstr(processorPkg::opLw, 5'd11, 5'd1, 16'd4);
        prog[13] = iInstr(processorPkg::opSw, 5'd11, 5'd1, 16'd8);
        prog[14] = iInstr(processorPkg::opBeq, 5'd2, 5'd1, 16'd2);
        prog[15] = iInstr(processorPkg::opAddiu, 5'd12, 5'd0, 16'd3);
        prog[16] = iInstr(processorPkg::opBne, 5'd2, 5'd1, 16'd2);
        prog[17] = iInstr(processorPkg::opAddiu, 5'd13, 5'd0, 16'd99);
        prog[18] = iInstr(processorPkg::opAddiu, 5'd14, 5'd0, 16'd98);
        prog[19] = iInstr(processorPkg::opLw, 5'd15, 5'd0, 16'd12);
        prog[20] = iInstr(processorPkg::opBeq, 5'd15, 5'd15, 16'd1);
        prog[21] = iInstr(processorPkg::opAddiu, 5'd16, 5'd0, 16'd1);
        prog[22] = rInstr(processorPkg::fnSlt, 5'd17, 5'd9, 5'd0);
        prog[23] = iInstr(processorPkg::opAddiu, 5'd18, 5'd17, 16'hffff);
        prog[24] = iInstr(processorPkg::opSw, 5'd18, 5'd0, 16'd28);
        prog[25] = iInstr(processorPkg::opBeq, 5'd0, 5'd0, 16'hffff);

        for (int i = 0; i < 64; i++) begin
            dmem[i] = nextRandomWord();
            modelMem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = 32'd0;
        end
        runModel();

        // Reset values
        repeat (2) @(posedge Clock);
        @(negedge Clock);
        checkAddr("InstrAddr", InstrAddr, 16'h0000);
        checkWord("MemWrite", 32'(MemWrite), 32'd0);
        checkWord("MemRead", 32'(MemRead), 32'd0);
        checkWord("nStall", 32'(nStall), 32'd1);
        @(posedge Clock);
        nReset <= 1'b1;

        // Halt address seen, left, then reached again by its own branch
        do @(negedge Clock); while (InstrAddr != finalAddr);
        do @(negedge Clock); while (InstrAddr == finalAddr);
        do begin
            @(negedge Clock);
            redirectCycles++;
        end while (InstrAddr != finalAddr);
        // Branch fetch edge to redirected fetch is two cycles
        checkWord("redirectCycles", 32'(redirectCycles), 32'd2);
        // Two older instructions still drain
        repeat (2) @(negedge Clock);
        done = 1'b1;

        for (int r = 0; r < 32; r++) begin
            @(posedge Clock);
            RegAddr <= 5'(r);
            @(negedge Clock);
            checkWord($sformatf("RegData[%0d]", r), RegData, modelRegs[r]);
        end
        checkWord("storesLeft", 32'(storeAddrQ.size()), 32'd0);
        checkWord("stallCycles", 32'(stallCycles), 32'(loadUsePairs));
        checkWord("assertFailures", 32'(u_dut.u_assert.failCount), 32'd0);

        $display("** PASS **");
        $finish;
    end

endmodule

// File: processor_assertions.sv
//--------------------------------------
// Assertions bound to the processor
// Memory strobes, stall hold, redirect
//--------------------------------------

`timescale 1ns/1ps

module processor_assertions (
    input logic        Clock,
    input logic        nReset,
    input logic        MemWrite,
    input logic        MemRead,
    input logic        nStall,
    input logic        branchTaken,
    input logic [15:0] branchTarget,
    input logic [15:0] InstrAddr
);

    // Count of failed assertions
    int failCount = 0;

    strobesExclusive: assert property (
        @(posedge Clock) disable iff (!nReset) !(MemWrite && MemRead)
    ) else begin
        failCount++;
        $error("MemWrite and MemRead high together");
    end

    // PC holds during a load-use stall
    stallHoldsPc: assert property (
        @(posedge Clock) disable iff (!nReset) (!nStall && !branchTaken) |=> $stable(InstrAddr)
    ) else begin
        failCount++;
        $error("InstrAddr moved while stalled");
    end

    branchRedirects: assert property (
        @(posedge Clock) disable iff (!nReset) branchTaken |=> InstrAddr == $past(branchTarget)
    ) else begin
        failCount++;
        $error("InstrAddr missed the branch target");
    end

endmodule

// File: project.f
processorPkg.sv
fetchStage.sv
decodeStage.sv
aluUnit.sv
hazardUnit.sv
processor.sv
processor_assertions.sv
processorTb.sv
